/* logic/store_axi_pkg.sv */
package store_axi_pkg;

	// field widths of the store path
	typedef logic [31:0] addr_t;   // byte address
	typedef logic [63:0] data_t;   // one CPU / AXI data word
	typedef logic [7:0]  strb_t;   // one strobe bit per byte lane
	typedef logic [7:0]  len_t;    // AXI beats minus one
	typedef logic [3:0]  id_t;
	typedef logic [2:0]  size_t;   // AXI AxSIZE encoding
	typedef logic [1:0]  resp_t;   // AXI BRESP encoding

	// transfer size, bytes = 1 << size
	localparam size_t SIZE_1B = 3'd0;
	localparam size_t SIZE_2B = 3'd1;
	localparam size_t SIZE_4B = 3'd2;
	localparam size_t SIZE_8B = 3'd3;

	// response codes as seen on B and passed back to the CPU
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_EXOKAY = 2'b01;
	localparam resp_t RESP_SLVERR = 2'b10;
	localparam resp_t RESP_DECERR = 2'b11;

	localparam logic [1:0] BURST_INCR = 2'b01;

	// write master phases
	typedef enum logic [1:0] {
		WR_IDLE,   // waiting for a buffered request
		WR_ADDR,   // AW offered
		WR_DATA,   // W beats running
		WR_RESP    // B wait, then CPU response
	} wr_state_e;

endpackage

/* logic/store_req_buffer.sv */
module store_req_buffer #(
	parameter int ADDR_W = 32,
	parameter int ID_W   = 4
) (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  req_valid_i,
	input  logic [ADDR_W-1:0]     req_addr_i,
	input  store_axi_pkg::size_t  req_size_i,
	input  store_axi_pkg::len_t   req_len_i,
	input  logic [ID_W-1:0]       req_id_i,
	input  store_axi_pkg::data_t  req_data_i,
	input  logic                  take_i,
	output logic                  req_ready_o,
	output logic                  buf_valid_o,
	output logic [ADDR_W-1:0]     buf_addr_o,
	output store_axi_pkg::size_t  buf_size_o,
	output store_axi_pkg::len_t   buf_len_o,
	output logic [ID_W-1:0]       buf_id_o,
	output store_axi_pkg::data_t  buf_data_o
);

	logic                 full;
	logic                 req_fire;
	store_axi_pkg::data_t pend_data;
	store_axi_pkg::data_t burst_data;   // word of the burst the master is running

	// the slot frees up in the same cycle the master takes it
	assign req_ready_o = ~full | take_i;
	assign req_fire    = req_valid_i & req_ready_o;
	assign buf_valid_o = full;
	assign buf_data_o  = burst_data;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			full <= 1'b0;
		end else if (req_fire) begin
			full <= 1'b1;   // refill wins over take
		end else if (take_i) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire) begin
			buf_addr_o <= req_addr_i;
			buf_size_o <= req_size_i;
			buf_len_o  <= req_len_i;
			buf_id_o   <= req_id_i;
			pend_data  <= req_data_i;
		end
		// pending slot may refill during the burst, so the word moves over here
		if (take_i)
			burst_data <= pend_data;
	end

	a_size_legal: assert property (@(posedge clk) disable iff (!reset_n)
		req_fire |-> req_size_i <= store_axi_pkg::SIZE_8B);

	// low address bits below the transfer size must be zero
	a_addr_aligned: assert property (@(posedge clk) disable iff (!reset_n)
		req_fire |-> (req_addr_i[2:0] & ~(3'b111 << req_size_i[1:0])) == 3'b000);

endmodule

/* logic/store_lane_align.sv */
module store_lane_align (
	input  logic [2:0]            beat_addr_i,   // byte offset inside the word
	input  store_axi_pkg::size_t  size_i,
	input  store_axi_pkg::data_t  data_i,
	output store_axi_pkg::data_t  data_o,
	output store_axi_pkg::strb_t  strb_o
);

	store_axi_pkg::strb_t size_mask;
	logic [15:0]          strb_wide;   // upper half catches lanes past 7

	always_comb begin
		case (size_i)
			store_axi_pkg::SIZE_1B: size_mask = 8'h01;
			store_axi_pkg::SIZE_2B: size_mask = 8'h03;
			store_axi_pkg::SIZE_4B: size_mask = 8'h0f;
			default:                size_mask = 8'hff;
		endcase
	end

	assign strb_wide = {8'h00, size_mask} << beat_addr_i;
	assign strb_o    = strb_wide[7:0];

	// word moves up by whole bytes
	assign data_o = data_i << {beat_addr_i, 3'b000};

	// an aligned beat always fits inside the word
	always_comb begin
		a_strb_in_word: assert final ($isunknown(strb_wide) || strb_wide[15:8] == 8'h00);
	end

endmodule

/* logic/axi_write_master.sv */
module axi_write_master #(
	parameter int ADDR_W = 32,
	parameter int ID_W   = 4
) (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  buf_valid_i,
	input  logic [ADDR_W-1:0]     buf_addr_i,
	input  store_axi_pkg::size_t  buf_size_i,
	input  store_axi_pkg::len_t   buf_len_i,
	input  logic [ID_W-1:0]       buf_id_i,
	input  logic                  awready_i,
	input  logic                  wready_i,
	input  logic                  bvalid_i,
	input  store_axi_pkg::resp_t  bresp_i,
	input  logic [ID_W-1:0]       bid_i,
	input  logic                  resp_ready_i,
	input  store_axi_pkg::data_t  lane_data_i,
	input  store_axi_pkg::strb_t  lane_strb_i,
	output logic                  take_o,
	output logic [2:0]            beat_addr_o,
	output logic                  awvalid_o,
	output logic [ADDR_W-1:0]     awaddr_o,
	output store_axi_pkg::len_t   awlen_o,
	output store_axi_pkg::size_t  awsize_o,
	output logic [1:0]            awburst_o,
	output logic [ID_W-1:0]       awid_o,
	output logic                  wvalid_o,
	output store_axi_pkg::data_t  wdata_o,
	output store_axi_pkg::strb_t  wstrb_o,
	output logic                  wlast_o,
	output logic                  bready_o,
	output logic                  resp_valid_o,
	output store_axi_pkg::resp_t  resp_code_o,
	output logic [ID_W-1:0]       resp_id_o
);

	store_axi_pkg::wr_state_e state;
	store_axi_pkg::len_t      beat_cnt;   // index of the next beat to load
	logic [2:0]               beat_lane;  // lane offset of the next beat to load
	logic                     aw_fire;
	logic                     w_fire;
	logic                     b_fire;
	logic                     r_fire;
	logic                     load_beat;
	logic                     last_next;

	assign aw_fire = awvalid_o & awready_i;
	assign w_fire  = wvalid_o & wready_i;
	assign b_fire  = bready_o & bvalid_i;
	assign r_fire  = resp_valid_o & resp_ready_i;

	assign take_o      = (state == store_axi_pkg::WR_IDLE) & buf_valid_i;
	assign beat_addr_o = beat_lane;

	// beat 0 goes out with the AW handshake, the rest one per W handshake
	assign load_beat = aw_fire | (w_fire & ~wlast_o);
	assign last_next = (state == store_axi_pkg::WR_ADDR) ? (awlen_o == '0)
	                                                    : (beat_cnt == awlen_o);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state        <= store_axi_pkg::WR_IDLE;
			awvalid_o    <= 1'b0;
			wvalid_o     <= 1'b0;
			bready_o     <= 1'b0;
			resp_valid_o <= 1'b0;
			beat_cnt     <= '0;
		end else begin
			case (state)
				store_axi_pkg::WR_IDLE: begin
					if (take_o) begin
						state     <= store_axi_pkg::WR_ADDR;
						awvalid_o <= 1'b1;
					end
				end
				store_axi_pkg::WR_ADDR: begin
					if (aw_fire) begin
						state     <= store_axi_pkg::WR_DATA;
						awvalid_o <= 1'b0;
						wvalid_o  <= 1'b1;
						beat_cnt  <= store_axi_pkg::len_t'(1);
					end
				end
				store_axi_pkg::WR_DATA: begin
					if (w_fire) begin
						if (wlast_o) begin
							state    <= store_axi_pkg::WR_RESP;
							wvalid_o <= 1'b0;
							bready_o <= 1'b1;
						end else begin
							beat_cnt <= beat_cnt + store_axi_pkg::len_t'(1);
						end
					end
				end
				store_axi_pkg::WR_RESP: begin
					if (b_fire) begin
						bready_o     <= 1'b0;
						resp_valid_o <= 1'b1;
					end
					if (r_fire) begin   // CPU took it, free for the next burst
						resp_valid_o <= 1'b0;
						state        <= store_axi_pkg::WR_IDLE;
					end
				end
				default: state <= store_axi_pkg::WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take_o) begin
			awaddr_o  <= buf_addr_i;
			awlen_o   <= buf_len_i;
			awsize_o  <= buf_size_i;
			awid_o    <= buf_id_i;
			awburst_o <= store_axi_pkg::BURST_INCR;
			beat_lane <= buf_addr_i[2:0];
		end
		if (load_beat) begin
			wdata_o   <= lane_data_i;
			wstrb_o   <= lane_strb_i;
			wlast_o   <= last_next;
			// step by the size, an 8 byte step wraps to the same lanes
			beat_lane <= beat_lane + 3'(4'b0001 << awsize_o[1:0]);
		end
		if (b_fire) begin
			resp_code_o <= bresp_i;
			resp_id_o   <= bid_i;
		end
	end

	a_w_after_aw: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(wvalid_o) |-> $past(aw_fire));

	a_aw_stable: assert property (@(posedge clk) disable iff (!reset_n)
		awvalid_o && !awready_i |=>
			awvalid_o && $stable({awaddr_o, awlen_o, awsize_o, awid_o, awburst_o}));

	a_w_stable: assert property (@(posedge clk) disable iff (!reset_n)
		wvalid_o && !wready_i |=> wvalid_o && $stable({wdata_o, wstrb_o, wlast_o}));

	a_resp_stable: assert property (@(posedge clk) disable iff (!reset_n)
		resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable({resp_code_o, resp_id_o}));

	// slave must answer with the ID of the burst in flight
	a_bid_match: assert property (@(posedge clk) disable iff (!reset_n)
		b_fire |-> bid_i == awid_o);

endmodule

/* logic/store_axi_top.sv */
module store_axi_top #(
	parameter int ADDR_W = 32,
	parameter int ID_W   = 4
) (
	input  logic                  clk,
	input  logic                  reset_n,
	// CPU store request
	input  logic                  req_valid_i,
	input  logic [ADDR_W-1:0]     req_addr_i,
	input  store_axi_pkg::size_t  req_size_i,
	input  store_axi_pkg::len_t   req_len_i,
	input  logic [ID_W-1:0]       req_id_i,
	input  store_axi_pkg::data_t  req_data_i,
	output logic                  req_ready_o,
	// CPU response
	output logic                  resp_valid_o,
	output store_axi_pkg::resp_t  resp_code_o,
	output logic [ID_W-1:0]       resp_id_o,
	input  logic                  resp_ready_i,
	// AXI AW
	output logic                  awvalid_o,
	output logic [ADDR_W-1:0]     awaddr_o,
	output store_axi_pkg::len_t   awlen_o,
	output store_axi_pkg::size_t  awsize_o,
	output logic [1:0]            awburst_o,
	output logic [ID_W-1:0]       awid_o,
	input  logic                  awready_i,
	// AXI W
	output logic                  wvalid_o,
	output store_axi_pkg::data_t  wdata_o,
	output store_axi_pkg::strb_t  wstrb_o,
	output logic                  wlast_o,
	input  logic                  wready_i,
	// AXI B
	input  logic                  bvalid_i,
	input  store_axi_pkg::resp_t  bresp_i,
	input  logic [ID_W-1:0]       bid_i,
	output logic                  bready_o
);

	logic                 buf_valid;
	logic [ADDR_W-1:0]    buf_addr;
	store_axi_pkg::size_t buf_size;
	store_axi_pkg::len_t  buf_len;
	logic [ID_W-1:0]      buf_id;
	store_axi_pkg::data_t buf_data;
	logic                 buf_take;
	logic [2:0]           beat_addr;
	store_axi_pkg::data_t lane_shift_data;
	store_axi_pkg::strb_t lane_strb;

	// widths are fixed by the package types
	if (ADDR_W != $bits(store_axi_pkg::addr_t) || ID_W != $bits(store_axi_pkg::id_t))
		begin : g_width_check
		$error("store_axi_top: ADDR_W/ID_W differ from store_axi_pkg");
	end

	store_req_buffer #(.ADDR_W(ADDR_W), .ID_W(ID_W)) u_req_buffer (
		.clk         (clk),
		.reset_n     (reset_n),
		.req_valid_i (req_valid_i),
		.req_addr_i  (req_addr_i),
		.req_size_i  (req_size_i),
		.req_len_i   (req_len_i),
		.req_id_i    (req_id_i),
		.req_data_i  (req_data_i),
		.take_i      (buf_take),
		.req_ready_o (req_ready_o),
		.buf_valid_o (buf_valid),
		.buf_addr_o  (buf_addr),
		.buf_size_o  (buf_size),
		.buf_len_o   (buf_len),
		.buf_id_o    (buf_id),
		.buf_data_o  (buf_data)
	);

	axi_write_master #(.ADDR_W(ADDR_W), .ID_W(ID_W)) u_write_master (
		.clk          (clk),
		.reset_n      (reset_n),
		.buf_valid_i  (buf_valid),
		.buf_addr_i   (buf_addr),
		.buf_size_i   (buf_size),
		.buf_len_i    (buf_len),
		.buf_id_i     (buf_id),
		.awready_i    (awready_i),
		.wready_i     (wready_i),
		.bvalid_i     (bvalid_i),
		.bresp_i      (bresp_i),
		.bid_i        (bid_i),
		.resp_ready_i (resp_ready_i),
		.lane_data_i  (lane_shift_data),
		.lane_strb_i  (lane_strb),
		.take_o       (buf_take),
		.beat_addr_o  (beat_addr),
		.awvalid_o    (awvalid_o),
		.awaddr_o     (awaddr_o),
		.awlen_o      (awlen_o),
		.awsize_o     (awsize_o),
		.awburst_o    (awburst_o),
		.awid_o       (awid_o),
		.wvalid_o     (wvalid_o),
		.wdata_o      (wdata_o),
		.wstrb_o      (wstrb_o),
		.wlast_o      (wlast_o),
		.bready_o     (bready_o),
		.resp_valid_o (resp_valid_o),
		.resp_code_o  (resp_code_o),
		.resp_id_o    (resp_id_o)
	);

	// size of the running burst, held in awsize_o while the beats go out
	store_lane_align u_lane_align (
		.beat_addr_i (beat_addr),
		.size_i      (awsize_o),
		.data_i      (buf_data),
		.data_o      (lane_shift_data),
		.strb_o      (lane_strb)
	);

endmodule

/* bench/tb_clock_gen.sv */
module tb_clock_gen (
	output logic clk_o,
	output logic reset_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;   // period 8
	end

	// low over the first 16 rising edges, released just after the last one
	initial begin
		reset_n_o = 1'b0;
		repeat (16) @(posedge clk_o);
		#1 reset_n_o = 1'b1;
	end

endmodule

/* bench/store_axi_tb.sv */
module store_axi_tb;

	localparam int NUM_REQ     = 200;
	localparam int MAX_CYCLES  = 50000;
	localparam int STALL_LIMIT = 300;

	logic                 clk;
	logic                 reset_n;
	logic                 req_valid_i, req_ready_o;
	store_axi_pkg::addr_t req_addr_i, awaddr_o;
	store_axi_pkg::size_t req_size_i, awsize_o;
	store_axi_pkg::len_t  req_len_i, awlen_o;
	store_axi_pkg::id_t   req_id_i, awid_o, bid_i, resp_id_o;
	store_axi_pkg::data_t req_data_i, wdata_o;
	store_axi_pkg::strb_t wstrb_o;
	store_axi_pkg::resp_t bresp_i, resp_code_o;
	logic [1:0]           awburst_o;
	logic                 awvalid_o, awready_i, wvalid_o, wready_i, wlast_o;
	logic                 bvalid_i, bready_o, resp_valid_o, resp_ready_i;

	// reference model in CPU order with the running burst at the head
	store_axi_pkg::addr_t q_addr[$];
	store_axi_pkg::size_t q_size[$];
	store_axi_pkg::len_t  q_len[$];
	store_axi_pkg::id_t   q_id[$];
	store_axi_pkg::data_t q_data[$];

	logic [31:0]          lcg_state = 32'h3b15_9ebf;
	bit                   buf_full_m, mst_busy_m;    // modeled occupancy
	bit                   aw_seen, b_pending, b_got;
	bit                   req_fire, b_fire;          // handshakes seen at the last edge
	int                   beat_k;
	store_axi_pkg::id_t   slv_id;                    // burst ID captured by the slave
	store_axi_pkg::resp_t b_code_m;                  // response the slave sent
	bit                   aw_stall, w_stall, r_stall;
	logic [127:0]         aw_hold, w_hold, r_hold;
	int                   issued, done_cnt, cycles;
	int                   stall_cnt[5];

	tb_clock_gen u_clock_gen (
		.clk_o     (clk),
		.reset_n_o (reset_n)
	);

	store_axi_top #(.ADDR_W(32), .ID_W(4)) u_store_axi_top (.*);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_val(input string name, input logic [127:0] exp,
			input logic [127:0] act);
		if (act !== exp)
			stop_on_error($sformatf("mismatch at %0t: %s expected %0h, got %0h",
				$time, name, exp, act));
	endtask

	// cycles spent waiting on one handshake
	task automatic watch_wait(input int idx, input bit waiting, input string what);
		if (waiting)
			stall_cnt[idx]++;
		else
			stall_cnt[idx] = 0;
		if (stall_cnt[idx] > STALL_LIMIT)
			stop_on_error($sformatf("timeout at %0t: %s", $time, what));
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		r = lcg_next();
		awready_i    = r[31] | r[30];
		wready_i     = r[29] | r[28];
		resp_ready_i = r[27] | r[26];
		if (req_fire)
			req_valid_i = 1'b0;
		if (!req_valid_i && issued < NUM_REQ && (r[25] | r[24])) begin
			a = lcg_next();
			b = lcg_next();
			req_valid_i = 1'b1;
			req_size_i  = store_axi_pkg::size_t'(a[31:30]);
			req_len_i   = store_axi_pkg::len_t'(a[29:27]);   // 1 to 8 beats
			req_id_i    = a[26:23];
			// halves swapped so the strong LCG bits reach the low address bits
			req_addr_i  = ({b[15:0], b[31:16]} >> a[31:30]) << a[31:30];
			req_data_i  = {lcg_next(), lcg_next()};
		end
		// slave B channel
		if (b_fire)
			bvalid_i = 1'b0;
		if (b_pending && !bvalid_i && r[22]) begin
			bvalid_i = 1'b1;
			bresp_i  = store_axi_pkg::resp_t'(r[21:20]);
			bid_i    = slv_id;
		end
	endtask

	task automatic observe_cycle();
		bit                   exp_take;
		bit                   aw_fire, w_fire, r_fire;
		int                   nbytes;
		logic [2:0]           lane;
		store_axi_pkg::data_t exp_data;
		store_axi_pkg::strb_t exp_strb;
		logic [127:0]         aw_now, w_now, r_now;
		aw_now   = {awvalid_o, awaddr_o, awlen_o, awsize_o, awburst_o, awid_o};
		w_now    = {wvalid_o, wdata_o, wstrb_o, wlast_o};
		r_now    = {resp_valid_o, resp_code_o, resp_id_o};
		exp_take = !mst_busy_m && buf_full_m;
		check_val("req_ready_o", !buf_full_m || exp_take, req_ready_o);
		check_val("awvalid_o", mst_busy_m && !aw_seen, awvalid_o);
		check_val("wvalid_o", aw_seen && !b_pending && !b_got, wvalid_o);
		check_val("bready_o", b_pending, bready_o);
		check_val("resp_valid_o", b_got, resp_valid_o);
		if (aw_stall)
			check_val("aw channel", aw_hold, aw_now);
		if (w_stall)
			check_val("w channel", w_hold, w_now);
		if (r_stall)
			check_val("response port", r_hold, r_now);

		req_fire = req_valid_i && req_ready_o;
		aw_fire  = awvalid_o && awready_i;
		w_fire   = wvalid_o && wready_i;
		b_fire   = bvalid_i && bready_o;
		r_fire   = resp_valid_o && resp_ready_i;

		if (aw_fire) begin
			if (q_addr.size() == 0)
				stop_on_error("AW handshake with no request outstanding");
			check_val("awaddr_o", q_addr[0], awaddr_o);
			check_val("awlen_o", q_len[0], awlen_o);
			check_val("awsize_o", q_size[0], awsize_o);
			check_val("awid_o", q_id[0], awid_o);
			check_val("awburst_o", store_axi_pkg::BURST_INCR, awburst_o);
			aw_seen = 1'b1;
			beat_k  = 0;
			slv_id  = awid_o;
		end
		if (w_fire) begin
			nbytes   = 1 << q_size[0];
			lane     = 3'(q_addr[0] + beat_k * nbytes);
			exp_data = q_data[0] << (8 * lane);
			exp_strb = 8'(((1 << nbytes) - 1) << lane);
			check_val("wdata_o", exp_data, wdata_o);
			check_val("wstrb_o", exp_strb, wstrb_o);
			check_val("wlast_o", beat_k == q_len[0], wlast_o);
			beat_k++;
			if (wlast_o)
				b_pending = 1'b1;
		end
		if (b_fire) begin
			b_pending = 1'b0;
			b_got     = 1'b1;
			b_code_m  = bresp_i;
		end
		if (r_fire) begin
			check_val("resp_code_o", b_code_m, resp_code_o);
			check_val("resp_id_o", q_id[0], resp_id_o);   // in order completion
			void'(q_addr.pop_front());
			void'(q_size.pop_front());
			void'(q_len.pop_front());
			void'(q_id.pop_front());
			void'(q_data.pop_front());
			done_cnt++;
			mst_busy_m = 1'b0;
			aw_seen    = 1'b0;
			b_got      = 1'b0;
		end
		if (req_fire) begin
			q_addr.push_back(req_addr_i);
			q_size.push_back(req_size_i);
			q_len.push_back(req_len_i);
			q_id.push_back(req_id_i);
			q_data.push_back(req_data_i);
			issued++;
		end

		// buffer and master occupancy after this edge
		if (exp_take)
			mst_busy_m = 1'b1;
		if (req_fire)
			buf_full_m = 1'b1;
		else if (exp_take)
			buf_full_m = 1'b0;

		aw_stall = awvalid_o && !awready_i;
		w_stall  = wvalid_o && !wready_i;
		r_stall  = resp_valid_o && !resp_ready_i;
		aw_hold  = aw_now;
		w_hold   = w_now;
		r_hold   = r_now;

		watch_wait(0, req_valid_i && !req_fire, "CPU request was never accepted");
		watch_wait(1, mst_busy_m && !aw_seen, "AW handshake never came");
		watch_wait(2, aw_seen && !b_pending && !b_got && !w_fire, "W handshake never came");
		watch_wait(3, b_pending, "B handshake never came");
		watch_wait(4, b_got, "CPU response handshake never came");
	endtask

	initial begin
		int n;
		req_valid_i  = 1'b0;
		req_addr_i   = '0;
		req_size_i   = '0;
		req_len_i    = '0;
		req_id_i     = '0;
		req_data_i   = '0;
		resp_ready_i = 1'b0;
		awready_i    = 1'b0;
		wready_i     = 1'b0;
		bvalid_i     = 1'b0;
		bresp_i      = '0;
		bid_i        = '0;
		n = 0;
		while (reset_n !== 1'b1) begin
			@(posedge clk);
			n++;
			if (n > 64)
				stop_on_error("reset_n was never released");
		end

		@(negedge clk);
		check_val("awvalid_o", 0, awvalid_o);
		check_val("wvalid_o", 0, wvalid_o);
		check_val("bready_o", 0, bready_o);
		check_val("resp_valid_o", 0, resp_valid_o);
		check_val("buf_valid", 0, u_store_axi_top.buf_valid);
		check_val("req_ready_o", 1, req_ready_o);

		cycles = 0;
		while (done_cnt < NUM_REQ && cycles < MAX_CYCLES) begin
			@(posedge clk);
			#1;
			drive_inputs();
			@(negedge clk);   // everything settled for the next edge
			observe_cycle();
			cycles++;
		end

		if (done_cnt < NUM_REQ) begin
			stop_on_error($sformatf("timeout: only %0d of %0d stores completed",
				done_cnt, NUM_REQ));
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

/* verilog.f */
logic/store_axi_pkg.sv
logic/store_req_buffer.sv
logic/store_lane_align.sv
logic/axi_write_master.sv
logic/store_axi_top.sv
bench/tb_clock_gen.sv
bench/store_axi_tb.sv

/* Bender.yml */
package:
  name: store_axi

sources:
  - logic/store_axi_pkg.sv
  - logic/store_req_buffer.sv
  - logic/store_lane_align.sv
  - logic/axi_write_master.sv
  - logic/store_axi_top.sv
  - target: simulation
    files:
      - bench/tb_clock_gen.sv
      - bench/store_axi_tb.sv
